/* verilog/search_pkg.sv */
`default_nettype none

package search_pkg;

    // Datapath widths
    localparam int block_w = 16;        // Plaintext and ciphertext width
    localparam int half_w  = 8;         // One Feistel half
    localparam int count_w = 16;        // Checked-value counter

    // Cipher depth, one pipeline stage per round
    localparam int rounds = 4;

    // Sweep FSM encoding
    localparam int state_w = 3;
    localparam logic [state_w-1:0] sweep_idle    = 3'd0;    // Waiting for start
    localparam logic [state_w-1:0] sweep_first   = 3'd1;    // Emitting the seed itself
    localparam logic [state_w-1:0] sweep_running = 3'd2;    // Emitting successors
    localparam logic [state_w-1:0] sweep_last    = 3'd3;    // Emitting the final value
    localparam logic [state_w-1:0] sweep_done    = 3'd4;    // Cycle complete

    // Left half sits in the upper bits
    typedef struct packed {
        logic [half_w-1:0] left;
        logic [half_w-1:0] right;
    } block_halves_t;

    // Whole word for the sweep and compare, halves for the rounds
    typedef union packed {
        logic [block_w-1:0] word;
        block_halves_t      half;
    } block_u;

endpackage

`default_nettype wire

/* verilog/block_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface block_stream_if;

    logic                valid;     // Source has a block
    logic                ready;     // Sink can take it
    search_pkg::block_u  data;      // Block being processed
    search_pkg::block_u  plain;     // Plaintext riding alongside
    logic                last;      // Final block of the sweep

    // Producer side
    modport source (
        output valid, data, plain, last,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid, data, plain, last,
        output ready
    );

endinterface

`default_nettype wire

/* verilog/lfsr_sweep.sv */
`timescale 1ns/1ps
`default_nettype none

module lfsr_sweep (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                start,         // Begin a sweep from idle or done
    input  wire logic                abort,         // Back to idle from anywhere
    input  wire search_pkg::block_u  seed,          // First value of the sweep
    input  wire search_pkg::block_u  polynomial,    // Galois tap mask
    block_stream_if.source           gen,
    output logic                     done
);

    logic [search_pkg::state_w-1:0] state;
    logic [search_pkg::state_w-1:0] state_nxt;

    search_pkg::block_u seed_reg;           // Sweep ends before returning here
    search_pkg::block_u poly_reg;
    search_pkg::block_u lfsr_reg;           // Value currently offered on gen

    logic [search_pkg::block_w-1:0] lfsr_nxt;      // Successor of lfsr_reg
    logic [search_pkg::block_w-1:0] lfsr_nxt2;     // Successor of the successor

    logic xfer;     // Handshake completes this cycle
    logic load;     // Start accepted, sample seed and taps

    // One right shift of a Galois LFSR, bit 0 is the feedback
    function automatic logic [search_pkg::block_w-1:0] lfsr_step(
        input logic [search_pkg::block_w-1:0] cur,
        input logic [search_pkg::block_w-1:0] poly
    );
        logic [search_pkg::block_w-1:0] nxt;
        nxt[search_pkg::block_w-1] = cur[0];    // Top bit takes the feedback
        for (int i = 0; i < search_pkg::block_w - 1; i++) begin
            nxt[i] = poly[i] ? (cur[i+1] ^ cur[0]) : cur[i+1];  // Tapped bits flip
        end
        return nxt;
    endfunction

    assign xfer = gen.valid && gen.ready;
    assign load = ((state == search_pkg::sweep_idle) || (state == search_pkg::sweep_done))
                  && start && !abort;

    // Lookahead so last is known while the value is still offered
    assign lfsr_nxt  = lfsr_step(lfsr_reg.word, poly_reg.word);
    assign lfsr_nxt2 = lfsr_step(lfsr_nxt, poly_reg.word);

    // Stream outputs, data and plain are the same word here
    assign gen.valid = (state == search_pkg::sweep_first)
                    || (state == search_pkg::sweep_running)
                    || (state == search_pkg::sweep_last);
    assign gen.data  = lfsr_reg;
    assign gen.plain = lfsr_reg;

    // Seed can be last only when it maps onto itself
    assign gen.last  = (state == search_pkg::sweep_last)
                    || ((state == search_pkg::sweep_first) && (lfsr_nxt == seed_reg.word));

    assign done = (state == search_pkg::sweep_done);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= search_pkg::sweep_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        if (abort) begin
            state_nxt = search_pkg::sweep_idle;     // Abort wins in every state
        end else begin
            case (state)
                search_pkg::sweep_idle,
                search_pkg::sweep_done: begin
                    if (start) begin
                        state_nxt = search_pkg::sweep_first;
                    end
                end
                search_pkg::sweep_first,
                search_pkg::sweep_running: begin
                    if (xfer) begin
                        if (gen.last) begin
                            state_nxt = search_pkg::sweep_done;    // One-value cycle
                        end else if (lfsr_nxt2 == seed_reg.word) begin
                            state_nxt = search_pkg::sweep_last;    // Next value closes the loop
                        end else begin
                            state_nxt = search_pkg::sweep_running;
                        end
                    end
                end
                search_pkg::sweep_last: begin
                    if (xfer) begin
                        state_nxt = search_pkg::sweep_done;
                    end
                end
                default: state_nxt = search_pkg::sweep_idle;
            endcase
        end
    end

    // Seed, taps and shift register
    always_ff @(posedge clk) begin
        if (load) begin
            seed_reg <= seed;
            poly_reg <= polynomial;
            lfsr_reg <= seed;                   // Seed goes out first
        end else if (xfer && !gen.last) begin
            lfsr_reg.word <= lfsr_nxt;          // Advance only on an accepted value
        end
    end

    // Offered value holds until the sink takes it
    a_gen_stable: assert property (@(posedge clk) disable iff (!rst_n)
        gen.valid && !gen.ready && !abort |=>
            gen.valid && $stable(gen.data) && $stable(gen.last));

endmodule

`default_nettype wire

/* verilog/feistel_core.sv */
`timescale 1ns/1ps
`default_nettype none

module feistel_core (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire search_pkg::block_u  key,       // Upper half for even rounds, lower for odd
    block_stream_if.sink             in_s,
    block_stream_if.source           out_s
);

    logic advance;      // Whole pipeline shifts this cycle

    logic [search_pkg::rounds-1:0] stage_valid;
    logic [search_pkg::rounds-1:0] stage_last;

    search_pkg::block_u stage_data  [search_pkg::rounds];   // Partially encrypted block
    search_pkg::block_u stage_plain [search_pkg::rounds];   // Plaintext carried along

    search_pkg::block_u round_in  [search_pkg::rounds];
    search_pkg::block_u round_out [search_pkg::rounds];

    // Round function on one half
    function automatic logic [search_pkg::half_w-1:0] round_f(
        input logic [search_pkg::half_w-1:0] r,
        input logic [search_pkg::half_w-1:0] k
    );
        logic [search_pkg::half_w-1:0] x;
        x = r ^ k;
        // Rotate left by 3, then add the key mod 256
        return {x[search_pkg::half_w-4:0], x[search_pkg::half_w-1:search_pkg::half_w-3]} + k;
    endfunction

    // One Feistel round with no final swap
    function automatic search_pkg::block_u round_step(
        input search_pkg::block_u            b,
        input logic [search_pkg::half_w-1:0] k
    );
        search_pkg::block_u r;
        r.half.left  = b.half.right;
        r.half.right = b.half.left ^ round_f(b.half.right, k);
        return r;
    endfunction

    // Key half for a given round
    function automatic logic [search_pkg::half_w-1:0] round_key(
        input search_pkg::block_u k,
        input int                 idx
    );
        return (idx % 2 == 0) ? k.half.left : k.half.right;
    endfunction

    // Freeze only when the tail holds a block nobody takes
    assign advance    = !stage_valid[search_pkg::rounds-1] || out_s.ready;
    assign in_s.ready = advance;

    always_comb begin
        round_in[0] = in_s.data;
        for (int i = 1; i < search_pkg::rounds; i++) begin
            round_in[i] = stage_data[i-1];          // Each stage feeds the next round
        end
        for (int i = 0; i < search_pkg::rounds; i++) begin
            round_out[i] = round_step(round_in[i], round_key(key, i));
        end
    end

    // Stage occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid[0] <= in_s.valid;
            for (int i = 1; i < search_pkg::rounds; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    // Payload moves in lockstep with the valids
    always_ff @(posedge clk) begin
        if (advance) begin
            stage_plain[0] <= in_s.plain;
            stage_last[0]  <= in_s.last;
            for (int i = 1; i < search_pkg::rounds; i++) begin
                stage_plain[i] <= stage_plain[i-1];
                stage_last[i]  <= stage_last[i-1];
            end
            for (int i = 0; i < search_pkg::rounds; i++) begin
                stage_data[i] <= round_out[i];
            end
        end
    end

    // Tail stage drives the ciphertext stream
    assign out_s.valid = stage_valid[search_pkg::rounds-1];
    assign out_s.data  = stage_data[search_pkg::rounds-1];
    assign out_s.plain = stage_plain[search_pkg::rounds-1];
    assign out_s.last  = stage_last[search_pkg::rounds-1];

    // Ciphertext on offer holds while the match unit stalls
    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_s.valid && !out_s.ready |=>
            out_s.valid && $stable(out_s.data) && $stable(out_s.plain) && $stable(out_s.last));

endmodule

`default_nettype wire

/* verilog/match_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module match_unit (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          start,     // New sweep, clear the tally
    input  wire logic                          abort,     // Drop pending match and tally
    input  wire search_pkg::block_u            target,    // Ciphertext being searched for
    block_stream_if.sink                       in_s,
    output logic                               match_valid,
    input  wire logic                          match_ready,
    output search_pkg::block_u                 match_plain,
    output logic [search_pkg::count_w-1:0]     checked_count,
    output logic                               finished
);

    logic accept;           // Ciphertext taken this cycle
    logic hit;              // Taken ciphertext equals target
    logic last_seen;        // Final ciphertext already taken
    logic last_done;        // Final ciphertext taken now or earlier
    logic match_valid_nxt;

    // Room when empty or emptying this cycle
    assign in_s.ready = !match_valid || match_ready;
    assign accept     = in_s.valid && in_s.ready;
    assign hit        = accept && (in_s.data.word == target.word);
    assign last_done  = last_seen || (accept && in_s.last);

    always_comb begin
        if (hit) begin
            match_valid_nxt = 1'b1;         // Load beats drain
        end else if (match_ready) begin
            match_valid_nxt = 1'b0;
        end else begin
            match_valid_nxt = match_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_valid   <= 1'b0;
            checked_count <= '0;
            last_seen     <= 1'b0;
            finished      <= 1'b0;
        end else begin
            match_valid <= abort ? 1'b0 : match_valid_nxt;
            if (start || abort) begin
                checked_count <= '0;
                last_seen     <= 1'b0;
                finished      <= 1'b0;
            end else begin
                if (accept) begin
                    checked_count <= checked_count + 1'b1;
                end
                if (accept && in_s.last) begin
                    last_seen <= 1'b1;
                end
                if (last_done && !match_valid_nxt) begin
                    finished <= 1'b1;       // Only once the match register is empty
                end
            end
        end
    end

    // Plaintext of the hit waits here for the consumer
    always_ff @(posedge clk) begin
        if (hit) begin
            match_plain <= in_s.plain;
        end
    end

    a_match_hold: assert property (@(posedge clk) disable iff (!rst_n)
        match_valid && !match_ready && !abort |=> match_valid && $stable(match_plain));

endmodule

`default_nettype wire

/* verilog/key_search_top.sv */
`timescale 1ns/1ps
`default_nettype none

module key_search_top (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              start,
    input  wire logic                              abort,
    input  wire logic [search_pkg::block_w-1:0]    seed,          // First plaintext
    input  wire logic [search_pkg::block_w-1:0]    polynomial,    // LFSR taps
    input  wire logic [search_pkg::block_w-1:0]    key,           // Fixed cipher key
    input  wire logic [search_pkg::block_w-1:0]    target,        // Ciphertext to find
    output logic                                   match_valid,
    input  wire logic                              match_ready,
    output logic [search_pkg::block_w-1:0]         match_plain,
    output logic [search_pkg::count_w-1:0]         checked_count,
    output logic                                   finished,
    output logic                                   done
);

    block_stream_if s_gen ();       // Plaintexts out of the sweep
    block_stream_if s_enc ();       // Ciphertexts out of the cipher

    // Plaintext generator
    lfsr_sweep u_sweep (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .abort      (abort),
        .seed       (seed),
        .polynomial (polynomial),
        .gen        (s_gen.source),
        .done       (done)
    );

    // Four-round cipher pipeline
    feistel_core u_cipher (
        .clk   (clk),
        .rst_n (rst_n),
        .key   (key),
        .in_s  (s_gen.sink),
        .out_s (s_enc.source)
    );

    // Compare, report and tally
    match_unit u_match (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .abort         (abort),
        .target        (target),
        .in_s          (s_enc.sink),
        .match_valid   (match_valid),
        .match_ready   (match_ready),
        .match_plain   (match_plain),
        .checked_count (checked_count),
        .finished      (finished)
    );

endmodule

`default_nettype wire

/* dv/key_search_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module key_search_tb;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    logic        abort;
    logic [15:0] seed;
    logic [15:0] polynomial;
    logic [15:0] key;
    logic [15:0] target;
    logic        match_ready = 1'b1;
    logic        match_valid;
    logic [15:0] match_plain;
    logic [15:0] checked_count;
    logic        finished;
    logic        done;

    logic [15:0] exp_q [$];         // Expected matches in sweep order
    logic [15:0] exp_count;         // Model cycle length of the running sweep
    logic        tracking = 1'b0;   // Order and finish checks armed
    logic        flush = 1'b0;      // Hold match_ready high while the pipeline drains
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          stalls = 0;        // Cycles a match waited on match_ready

    // Monitor history updated on every falling edge
    logic        rst_d = 1'b0;
    logic        hold_prev = 1'b0;
    logic [15:0] held_plain;
    logic        abort_prev = 1'b0;
    logic        fin_prev = 1'b0;

    logic [15:0] rnd = 16'd58;      // Stall generator state
    logic        bit_a;
    logic        bit_b;
    logic        ready_nxt;

    int          full_len;
    int          abort_len;
    int          restart_len;
    int          short_len;
    logic [15:0] short_poly;
    logic        found;

    key_search_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .abort         (abort),
        .seed          (seed),
        .polynomial    (polynomial),
        .key           (key),
        .target        (target),
        .match_valid   (match_valid),
        .match_ready   (match_ready),
        .match_plain   (match_plain),
        .checked_count (checked_count),
        .finished      (finished),
        .done          (done)
    );

    always #20 clk = ~clk;          // 40 ns period

    // Galois step shifts right and folds in the taps when bit 0 falls out
    function automatic logic [15:0] next_value(input logic [15:0] v, input logic [15:0] p);
        return (v >> 1) ^ ({16{v[0]}} & {1'b1, p[14:0]});
    endfunction

    // Steps until the seed comes back
    function automatic int cycle_length(input logic [15:0] s, input logic [15:0] p);
        int          n;
        logic [15:0] v;
        n = 0;
        v = s;
        do begin
            v = next_value(v, p);
            n++;
        end while (v != s && n < 70000);
        return n;
    endfunction

    function automatic logic [15:0] nth_value(input logic [15:0] s, input logic [15:0] p,
                                              input int idx);
        logic [15:0] v;
        v = s;
        for (int i = 0; i < idx; i++) begin
            v = next_value(v, p);
        end
        return v;
    endfunction

    // Four Feistel rounds with even rounds on the upper key byte
    function automatic logic [15:0] encrypt_block(input logic [15:0] pt, input logic [15:0] k);
        logic [7:0] l;
        logic [7:0] r;
        logic [7:0] t;
        logic [7:0] rk;
        l = pt[15:8];
        r = pt[7:0];
        for (int n = 0; n < 4; n++) begin
            rk = (n % 2 == 0) ? k[15:8] : k[7:0];
            t  = r ^ rk;
            t  = ((t << 3) | (t >> 5)) + rk;    // rotl 3 then add
            t  = l ^ t;
            l  = r;
            r  = t;
        end
        return {l, r};                          // No final swap
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] fib_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic expect_value(input string name, input logic [15:0] actual,
                                input logic [15:0] expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Load a sweep, pick its target from the model and pulse start
    task automatic begin_sweep(input logic [15:0] s, input logic [15:0] p, input int tidx);
        int          len;
        logic [15:0] v;
        len = cycle_length(s, p);
        @(posedge clk);
        #2;
        seed       = s;
        polynomial = p;
        target     = encrypt_block(nth_value(s, p, tidx), key);
        exp_q.delete();
        v = s;
        for (int i = 0; i < len; i++) begin
            if (encrypt_block(v, key) == target) begin
                exp_q.push_back(v);
            end
            v = next_value(v, p);
        end
        exp_count = 16'(len);
        tracking  = 1'b1;
        start     = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic wait_finish();
        do begin
            @(negedge clk);
        end while (!finished);
    endtask

    task automatic pulse_abort(input int drain);
        @(posedge clk);
        #2;
        abort    = 1'b1;
        tracking = 1'b0;            // Drained values are still checked for target
        flush    = 1'b1;
        @(posedge clk);
        #2;
        abort = 1'b0;
        repeat (drain) @(posedge clk);
        #2;
        flush = 1'b0;
    endtask

    // Random stall drops ready when two fresh bits are both zero
    always @(posedge clk) begin
        rnd       = fib_step(rnd);
        bit_a     = rnd[0];
        rnd       = fib_step(rnd);
        bit_b     = rnd[0];
        ready_nxt = flush || bit_a || bit_b;
        #2;
        match_ready = ready_nxt;
    end

    always @(negedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, sweep never finished", cycles);
            $display("Checks run %0d, errors %0d", checks, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Checks sampled mid-cycle where DUT outputs are settled
    always @(negedge clk) begin
        if (!rst_n || !rst_d) begin
            expect_value("match_valid in reset", 16'(match_valid), 16'h0);
            expect_value("done in reset", 16'(done), 16'h0);
            expect_value("finished in reset", 16'(finished), 16'h0);
            expect_value("checked_count in reset", checked_count, 16'h0);
        end
        rst_d = rst_n;
        if (rst_n && match_valid && match_ready) begin      // Transfer on the next edge
            expect_value("encrypted match_plain", encrypt_block(match_plain, key), target);
            if (tracking) begin
                checks++;
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("Extra match %h delivered that the sweep should not produce",
                             match_plain);
                end
                if (exp_q.size() > 0) begin
                    expect_value("match_plain", match_plain, exp_q.pop_front());
                end
            end
        end
        if (rst_n && hold_prev) begin
            expect_value("stalled match_valid", 16'(match_valid), 16'h1);
            expect_value("stalled match_plain", match_plain, held_plain);
        end
        hold_prev  = rst_n && match_valid && !match_ready && !abort;
        held_plain = match_plain;
        if (hold_prev) begin
            stalls++;
        end
        if (rst_n && abort_prev) begin
            expect_value("done after abort", 16'(done), 16'h0);
            expect_value("finished after abort", 16'(finished), 16'h0);
        end
        abort_prev = abort;
        if (rst_n && tracking && finished && !fin_prev) begin
            expect_value("checked_count", checked_count, exp_count);
            expect_value("done at finish", 16'(done), 16'h1);
            checks++;
            assert (exp_q.size() == 0) else begin
                errors++;
                $display("Sweep finished with %0d matches never delivered", exp_q.size());
            end
        end
        fin_prev = finished;
    end

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        abort      = 1'b0;
        seed       = 16'h0;
        polynomial = 16'h0;
        key        = 16'h3C5A;
        target     = 16'h0;
        exp_count  = 16'h0;
        // Look for a reducible tap set with a short cycle through 0x0001
        short_poly = 16'h8000;      // Pure rotation if nothing shorter turns up
        found      = 1'b0;
        for (int c = 1; c < 256; c++) begin
            if (!found) begin
                short_len = cycle_length(16'h0001, 16'h8000 | 16'(c));
                if (short_len >= 32 && short_len <= 4096) begin
                    short_poly = 16'h8000 | 16'(c);
                    found      = 1'b1;
                end
            end
        end
        short_len   = cycle_length(16'h0001, short_poly);
        full_len    = cycle_length(16'hACE1, 16'hB400);
        abort_len   = cycle_length(16'h0BAD, 16'hB400);
        restart_len = cycle_length(16'h1234, 16'hB400);
        cycle_limit = 3 * (full_len + abort_len + restart_len + 6 * short_len) + 1000;

        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        begin_sweep(16'hACE1, 16'hB400, 40000);     // Full maximal-length sweep
        wait_finish();
        pulse_abort(2);                             // Clears done and finished

        begin_sweep(16'h0BAD, 16'hB400, 1000);      // Abort once a match is out
        repeat (3000) @(posedge clk);
        pulse_abort(12);

        begin_sweep(16'h1234, 16'hB400, restart_len - 1);    // Hit on the last value
        wait_finish();

        for (int k = 0; k < 6; k++) begin
            begin_sweep(16'h0001, short_poly, (short_len - 1) * k / 5);
            wait_finish();
        end
        repeat (8) @(negedge clk);

        checks++;
        assert (stalls > 0) else begin
            errors++;
            $display("No match ever waited on a low match_ready so back-pressure was not reached");
        end

        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* key_search_top.f */
verilog/search_pkg.sv
verilog/block_stream_if.sv
verilog/lfsr_sweep.sv
verilog/feistel_core.sv
verilog/match_unit.sv
verilog/key_search_top.sv
dv/key_search_tb.sv

/* Makefile */
TB  = key_search_tb
OBJ = obj_dir
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f key_search_top.f --top-module $(TB)

sim:
	verilator --binary --timing --assert -f key_search_top.f --top-module $(TB) \
		-Mdir $(OBJ) -o $(TB)
	-./$(OBJ)/$(TB) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ) $(LOG)
